/* mem_pkg.sv */
// Line geometry, request size codes and requester codes
// for the main memory subsystem
package mem_pkg;

   // One line is 32 bytes wide
   localparam int LINE_BYTES = 32;
   localparam int LINE_W = LINE_BYTES * 8;

   // Byte offset field inside a line
   localparam int OFS_W = $clog2(LINE_BYTES);

   // Request size, 0 is the whole line, 1 to 4 is a byte count
   typedef logic [2:0] size_t;

   localparam size_t SIZE_FULL = 3'd0;

   // Requesters sharing the memory
   typedef enum logic [1:0] {
      SRC_IC  = 2'd0,
      SRC_DC  = 2'd1,
      SRC_DMA = 2'd2
   } src_t;

   localparam int N_SRC = 3;

endpackage

/* mem_bank.sv */
// One memory bank of full lines
// Byte-lane write enables, registered read port
module mem_bank #(
   parameter int LINES = 128,
   localparam int IDX_W = $clog2(LINES)
) (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic                            en,
   input  logic                            we,
   input  logic [IDX_W-1:0]                line_idx,
   input  logic [mem_pkg::LINE_BYTES-1:0]  byte_we,
   input  logic [mem_pkg::LINE_W-1:0]      wdata,
   output logic [mem_pkg::LINE_W-1:0]      rdata
);
   import mem_pkg::*;

   logic [LINE_W-1:0] lines [LINES];

   // Write only the enabled byte lanes
   always_ff @(posedge clk) begin
      if (en && we) begin
         for (int i = 0; i < LINE_BYTES; i++) begin
            if (byte_we[i]) begin
               lines[line_idx][i*8 +: 8] <= wdata[i*8 +: 8];
            end
         end
      end
   end

   // Read line held until the next read of this bank
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rdata <= '0;
      end else if (en && !we) begin
         rdata <= lines[line_idx];
      end
   end

endmodule

/* byte_lane_unit.sv */
// Byte write mask and write/read data alignment
// by byte offset and request size
module byte_lane_unit (
   input  logic [mem_pkg::OFS_W-1:0]       offset,
   input  mem_pkg::size_t                  size,
   input  logic [mem_pkg::LINE_W-1:0]      wdata_in,
   input  logic [mem_pkg::LINE_W-1:0]      line_in,
   output logic [mem_pkg::LINE_BYTES-1:0]  byte_we,
   output logic [mem_pkg::LINE_W-1:0]      wdata_out,
   output logic [mem_pkg::LINE_W-1:0]      rdata_out
);
   import mem_pkg::*;

   logic                  full;
   logic [OFS_W:0]        first;
   logic [OFS_W:0]        last_excl;
   logic [OFS_W-1:0]      shift_ofs;
   logic [LINE_BYTES-1:0] keep;
   logic [LINE_W-1:0]     line_down;

   // Full-line requests ignore the offset
   assign full = (size == SIZE_FULL);
   assign shift_ofs = full ? '0 : offset;

   // Lane range, one past the end may reach beyond lane 31
   assign first = {1'b0, offset};
   assign last_excl = first + (OFS_W + 1)'(size);

   always_comb begin
      byte_we = '0;
      for (int i = 0; i < LINE_BYTES; i++) begin
         if (full) begin
            byte_we[i] = 1'b1;
         end else if ((OFS_W + 1)'(i) >= first && (OFS_W + 1)'(i) < last_excl) begin
            // Lanes past the line end simply never match
            byte_we[i] = 1'b1;
         end
      end
   end

   // Low bytes of the bus move up to the addressed lanes
   assign wdata_out = wdata_in << {shift_ofs, 3'b000};

   // Selected bytes move down to lane 0
   assign line_down = line_in >> {shift_ofs, 3'b000};

   // Keep only as many low lanes as were requested
   always_comb begin
      keep = '0;
      for (int i = 0; i < LINE_BYTES; i++) begin
         if (full || (i < int'(size))) begin
            keep[i] = 1'b1;
         end
      end
   end

   always_comb begin
      rdata_out = '0;
      for (int i = 0; i < LINE_BYTES; i++) begin
         if (keep[i]) begin
            rdata_out[i*8 +: 8] = line_down[i*8 +: 8];
         end
      end
   end

endmodule

/* main_memory.sv */
// Wishbone classic memory slave with bank decode,
// bank instances and read-data select
module main_memory #(
   parameter int BANK_LINES = 128,
   parameter int N_BANKS = 8,
   localparam int ADR_W = $clog2(N_BANKS) + $clog2(BANK_LINES) + mem_pkg::OFS_W
) (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        cyc,
   input  logic                        stb,
   input  logic                        we,
   input  logic [ADR_W-1:0]            adr,
   input  mem_pkg::size_t              size,
   input  logic [mem_pkg::LINE_W-1:0]  dat_w,
   output logic                        ack,
   output logic [mem_pkg::LINE_W-1:0]  dat_r
);
   import mem_pkg::*;

   localparam int BANK_W = $clog2(N_BANKS);
   localparam int IDX_W = $clog2(BANK_LINES);

   logic                  access;
   logic [BANK_W-1:0]     bank_sel;
   logic [IDX_W-1:0]      line_idx;
   logic [OFS_W-1:0]      offset;
   logic [BANK_W-1:0]     bank_q;
   logic [OFS_W-1:0]      ofs_q;
   size_t                 size_q;
   logic [OFS_W-1:0]      lane_ofs;
   size_t                 lane_size;
   logic [N_BANKS-1:0]    bank_en;
   logic [LINE_BYTES-1:0] byte_we;
   logic [LINE_W-1:0]     wdata_al;
   logic [LINE_W-1:0]     line_sel;
   logic [LINE_W-1:0]     bank_rdata [N_BANKS];

   // New transfer, never in the ack cycle
   assign access = cyc && stb && !ack;

   // Bank on top, line in the middle, byte offset at the bottom
   assign bank_sel = adr[ADR_W-1 -: BANK_W];
   assign line_idx = adr[OFS_W +: IDX_W];
   assign offset = adr[OFS_W-1:0];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ack <= 1'b0;
         bank_q <= '0;
         ofs_q <= '0;
         size_q <= SIZE_FULL;
      end else begin
         ack <= access;
         if (access) begin
            bank_q <= bank_sel;
            ofs_q <= offset;
            size_q <= size;
         end
      end
   end

   // Write path needs the live request, read path the stored one in the ack cycle
   assign lane_ofs = ack ? ofs_q : offset;
   assign lane_size = ack ? size_q : size;

   byte_lane_unit u_lanes (
      .offset    (lane_ofs),
      .size      (lane_size),
      .wdata_in  (dat_w),
      .line_in   (line_sel),
      .byte_we   (byte_we),
      .wdata_out (wdata_al),
      .rdata_out (dat_r)
   );

   for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
      assign bank_en[b] = access && (bank_sel == BANK_W'(b));

      mem_bank #(
         .LINES (BANK_LINES)
      ) u_bank (
         .clk      (clk),
         .arst_n   (arst_n),
         .en       (bank_en[b]),
         .we       (we),
         .line_idx (line_idx),
         .byte_we  (byte_we),
         .wdata    (wdata_al),
         .rdata    (bank_rdata[b])
      );
   end

   // Line from the bank that served the last read
   assign line_sel = bank_rdata[bank_q];

endmodule

/* mem_arbiter.sv */
// Round-robin arbiter joining three Wishbone classic masters
// to the single memory slave
module mem_arbiter #(
   parameter int BANK_LINES = 128,
   parameter int N_BANKS = 8,
   localparam int ADR_W = $clog2(N_BANKS) + $clog2(BANK_LINES) + mem_pkg::OFS_W
) (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic [mem_pkg::N_SRC-1:0]   s_cyc,
   input  logic [mem_pkg::N_SRC-1:0]   s_stb,
   input  logic [mem_pkg::N_SRC-1:0]   s_we,
   input  logic [ADR_W-1:0]            s_adr [mem_pkg::N_SRC],
   input  mem_pkg::size_t              s_size [mem_pkg::N_SRC],
   input  logic [mem_pkg::LINE_W-1:0]  s_dat_w [mem_pkg::N_SRC],
   output logic [mem_pkg::N_SRC-1:0]   s_ack,
   output logic [mem_pkg::LINE_W-1:0]  s_dat_r [mem_pkg::N_SRC],
   output logic                        m_cyc,
   output logic                        m_stb,
   output logic                        m_we,
   output logic [ADR_W-1:0]            m_adr,
   output mem_pkg::size_t              m_size,
   output logic [mem_pkg::LINE_W-1:0]  m_dat_w,
   input  logic                        m_ack,
   input  logic [mem_pkg::LINE_W-1:0]  m_dat_r
);
   import mem_pkg::*;

   src_t             owner_q;
   logic             owner_vld_q;
   src_t             last_q;
   src_t             pick;
   logic             pick_vld;
   logic [N_SRC-1:0] grant;

   // Search starts one past the last owner
   always_comb begin
      int idx;
      pick = last_q;
      pick_vld = 1'b0;
      for (int k = 1; k <= N_SRC; k++) begin
         idx = (int'(last_q) + k) % N_SRC;
         if (!pick_vld && s_cyc[idx]) begin
            pick = src_t'(idx);
            pick_vld = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         owner_q <= SRC_IC;
         owner_vld_q <= 1'b0;
         last_q <= SRC_DMA;
      end else if (!owner_vld_q) begin
         if (pick_vld) begin
            owner_q <= pick;
            owner_vld_q <= 1'b1;
         end
      end else if (!s_cyc[owner_q]) begin
         // Owner dropped cyc, free the bus
         owner_vld_q <= 1'b0;
         last_q <= owner_q;
      end
   end

   always_comb begin
      grant = '0;
      if (owner_vld_q) begin
         grant[owner_q] = 1'b1;
      end
   end

   // Owner request goes straight through to the slave
   assign m_cyc = |(grant & s_cyc);
   assign m_stb = |(grant & s_stb);
   assign m_we = s_we[owner_q];
   assign m_adr = s_adr[owner_q];
   assign m_size = s_size[owner_q];
   assign m_dat_w = s_dat_w[owner_q];

   // Response only to the owner
   always_comb begin
      for (int i = 0; i < N_SRC; i++) begin
         s_ack[i] = grant[i] && m_ack;
         s_dat_r[i] = grant[i] ? m_dat_r : '0;
      end
   end

endmodule

/* mem_subsystem.sv */
// Memory subsystem top, arbiter in front of main memory
module mem_subsystem #(
   parameter int BANK_LINES = 128,
   parameter int N_BANKS = 8,
   localparam int ADR_W = $clog2(N_BANKS) + $clog2(BANK_LINES) + mem_pkg::OFS_W
) (
   input  logic                        clk,
   input  logic                        arst_n,
   // Instruction cache
   input  logic                        ic_cyc,
   input  logic                        ic_stb,
   input  logic                        ic_we,
   input  logic [ADR_W-1:0]            ic_adr,
   input  mem_pkg::size_t              ic_size,
   input  logic [mem_pkg::LINE_W-1:0]  ic_dat_w,
   output logic                        ic_ack,
   output logic [mem_pkg::LINE_W-1:0]  ic_dat_r,
   // Data cache
   input  logic                        dc_cyc,
   input  logic                        dc_stb,
   input  logic                        dc_we,
   input  logic [ADR_W-1:0]            dc_adr,
   input  mem_pkg::size_t              dc_size,
   input  logic [mem_pkg::LINE_W-1:0]  dc_dat_w,
   output logic                        dc_ack,
   output logic [mem_pkg::LINE_W-1:0]  dc_dat_r,
   // DMA
   input  logic                        dma_cyc,
   input  logic                        dma_stb,
   input  logic                        dma_we,
   input  logic [ADR_W-1:0]            dma_adr,
   input  mem_pkg::size_t              dma_size,
   input  logic [mem_pkg::LINE_W-1:0]  dma_dat_w,
   output logic                        dma_ack,
   output logic [mem_pkg::LINE_W-1:0]  dma_dat_r
);
   import mem_pkg::*;

   logic [N_SRC-1:0]  s_cyc;
   logic [N_SRC-1:0]  s_stb;
   logic [N_SRC-1:0]  s_we;
   logic [N_SRC-1:0]  s_ack;
   logic [ADR_W-1:0]  s_adr [N_SRC];
   size_t             s_size [N_SRC];
   logic [LINE_W-1:0] s_dat_w [N_SRC];
   logic [LINE_W-1:0] s_dat_r [N_SRC];
   logic              m_cyc;
   logic              m_stb;
   logic              m_we;
   logic [ADR_W-1:0]  m_adr;
   size_t             m_size;
   logic [LINE_W-1:0] m_dat_w;
   logic              m_ack;
   logic [LINE_W-1:0] m_dat_r;

   // Masters gathered into arbiter slots by source code
   assign s_cyc = {dma_cyc, dc_cyc, ic_cyc};
   assign s_stb = {dma_stb, dc_stb, ic_stb};
   assign s_we = {dma_we, dc_we, ic_we};
   assign s_adr[SRC_IC] = ic_adr;
   assign s_adr[SRC_DC] = dc_adr;
   assign s_adr[SRC_DMA] = dma_adr;
   assign s_size[SRC_IC] = ic_size;
   assign s_size[SRC_DC] = dc_size;
   assign s_size[SRC_DMA] = dma_size;
   assign s_dat_w[SRC_IC] = ic_dat_w;
   assign s_dat_w[SRC_DC] = dc_dat_w;
   assign s_dat_w[SRC_DMA] = dma_dat_w;

   assign ic_ack = s_ack[SRC_IC];
   assign dc_ack = s_ack[SRC_DC];
   assign dma_ack = s_ack[SRC_DMA];
   assign ic_dat_r = s_dat_r[SRC_IC];
   assign dc_dat_r = s_dat_r[SRC_DC];
   assign dma_dat_r = s_dat_r[SRC_DMA];

   mem_arbiter #(
      .BANK_LINES (BANK_LINES),
      .N_BANKS    (N_BANKS)
   ) u_arbiter (
      .clk     (clk),
      .arst_n  (arst_n),
      .s_cyc   (s_cyc),
      .s_stb   (s_stb),
      .s_we    (s_we),
      .s_adr   (s_adr),
      .s_size  (s_size),
      .s_dat_w (s_dat_w),
      .s_ack   (s_ack),
      .s_dat_r (s_dat_r),
      .m_cyc   (m_cyc),
      .m_stb   (m_stb),
      .m_we    (m_we),
      .m_adr   (m_adr),
      .m_size  (m_size),
      .m_dat_w (m_dat_w),
      .m_ack   (m_ack),
      .m_dat_r (m_dat_r)
   );

   main_memory #(
      .BANK_LINES (BANK_LINES),
      .N_BANKS    (N_BANKS)
   ) u_memory (
      .clk    (clk),
      .arst_n (arst_n),
      .cyc    (m_cyc),
      .stb    (m_stb),
      .we     (m_we),
      .adr    (m_adr),
      .size   (m_size),
      .dat_w  (m_dat_w),
      .ack    (m_ack),
      .dat_r  (m_dat_r)
   );

endmodule

/* tb_clock_gen.sv */
// Free-running testbench clock
module tb_clock_gen #(
   parameter int PERIOD = 4
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2) clk = ~clk;
      end
   end

endmodule

/* mem_subsystem_assertions.sv */
// Bound checks on the memory slave handshake and the arbiter grant
module mem_subsystem_assertions (
   input logic                       clk,
   input logic                       arst_n,
   input logic                       cyc,
   input logic                       stb,
   input logic                       ack,
   input logic [mem_pkg::N_SRC-1:0]  grant
);

   // ack answers a request seen one cycle earlier
   ack_after_request: assert property (
      @(posedge clk) disable iff (!arst_n) ack |-> $past(cyc && stb)
   ) else $error("ack raised without cyc and stb in the previous cycle");

   // One transfer, one ack cycle
   ack_single_cycle: assert property (
      @(posedge clk) disable iff (!arst_n) ack |=> !ack
   ) else $error("ack stayed high for two cycles in a row");

   // Owner keeps the bus while its cyc stays high
   grant_held: assert property (
      @(posedge clk) disable iff (!arst_n) cyc |=> $stable(grant)
   ) else $error("grant changed while the owner still held cyc");

endmodule

/* mem_subsystem_tb.sv */
// Memory subsystem testbench with a byte-array reference model,
// three Wishbone masters and a read-data checker
module mem_subsystem_tb;
   import mem_pkg::*;

   localparam int BANK_LINES = 128;
   localparam int N_BANKS = 8;
   localparam int ADR_W = $clog2(N_BANKS) + $clog2(BANK_LINES) + OFS_W;
   localparam int N_LINES = N_BANKS * BANK_LINES;
   localparam int ACK_TIMEOUT = 50;

   logic              clk;
   logic              arst_n;
   logic [N_SRC-1:0]  cyc;
   logic [N_SRC-1:0]  stb;
   logic [N_SRC-1:0]  we;
   logic [ADR_W-1:0]  adr [N_SRC];
   size_t             req_size [N_SRC];
   logic [LINE_W-1:0] dat_w [N_SRC];
   logic [N_SRC-1:0]  ack;
   logic [LINE_W-1:0] dat_r [N_SRC];

   logic [7:0]        model_mem [N_LINES*LINE_BYTES];
   logic [31:0]       rng_state;
   logic [LINE_W-1:0] exp_q [$];
   logic [LINE_W-1:0] act_q [$];
   string             name_q [$];
   src_t              order_q [$];
   int                data_errors;
   int                check_errors;
   int                timeouts;

   tb_clock_gen #(.PERIOD (4)) u_clk (.clk (clk));

   mem_subsystem #(
      .BANK_LINES (BANK_LINES),
      .N_BANKS    (N_BANKS)
   ) dut0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .ic_cyc    (cyc[SRC_IC]),
      .ic_stb    (stb[SRC_IC]),
      .ic_we     (we[SRC_IC]),
      .ic_adr    (adr[SRC_IC]),
      .ic_size   (req_size[SRC_IC]),
      .ic_dat_w  (dat_w[SRC_IC]),
      .ic_ack    (ack[SRC_IC]),
      .ic_dat_r  (dat_r[SRC_IC]),
      .dc_cyc    (cyc[SRC_DC]),
      .dc_stb    (stb[SRC_DC]),
      .dc_we     (we[SRC_DC]),
      .dc_adr    (adr[SRC_DC]),
      .dc_size   (req_size[SRC_DC]),
      .dc_dat_w  (dat_w[SRC_DC]),
      .dc_ack    (ack[SRC_DC]),
      .dc_dat_r  (dat_r[SRC_DC]),
      .dma_cyc   (cyc[SRC_DMA]),
      .dma_stb   (stb[SRC_DMA]),
      .dma_we    (we[SRC_DMA]),
      .dma_adr   (adr[SRC_DMA]),
      .dma_size  (req_size[SRC_DMA]),
      .dma_dat_w (dat_w[SRC_DMA]),
      .dma_ack   (ack[SRC_DMA]),
      .dma_dat_r (dat_r[SRC_DMA])
   );

   // Slave side of the arbiter is the memory handshake
   bind mem_arbiter mem_subsystem_assertions u_assertions (
      .clk    (clk),
      .arst_n (arst_n),
      .cyc    (m_cyc),
      .stb    (m_stb),
      .ack    (m_ack),
      .grant  (grant)
   );

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_state = x;
      return x;
   endfunction

   function automatic logic [LINE_W-1:0] random_line();
      logic [LINE_W-1:0] r;
      for (int i = 0; i < LINE_W / 32; i++) begin
         r[i*32 +: 32] = next_random();
      end
      return r;
   endfunction

   // Every address bit ends up in its byte
   function automatic logic [LINE_W-1:0] fill_line(input int line_no);
      logic [LINE_W-1:0] r;
      int a;
      for (int i = 0; i < LINE_BYTES; i++) begin
         a = line_no * LINE_BYTES + i;
         r[i*8 +: 8] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
      end
      return r;
   endfunction

   function automatic logic [ADR_W-1:0] make_adr(input int line_no, input int ofs);
      return ADR_W'(line_no * LINE_BYTES + ofs);
   endfunction

   // Expected read data, selected bytes in the low lanes, clipped at the line end
   function automatic logic [LINE_W-1:0] expected_read(input logic [ADR_W-1:0] a,
                                                       input size_t s);
      logic [LINE_W-1:0] r;
      int ofs;
      int base;
      int n;
      ofs = int'(a) % LINE_BYTES;
      base = int'(a) - ofs;
      n = int'(s);
      r = '0;
      if (s == SIZE_FULL) begin
         ofs = 0;
         n = LINE_BYTES;
      end
      for (int i = 0; i < n; i++) begin
         if (ofs + i < LINE_BYTES) begin
            r[i*8 +: 8] = model_mem[base + ofs + i];
         end
      end
      return r;
   endfunction

   function automatic void model_write(input logic [ADR_W-1:0] a, input size_t s,
                                       input logic [LINE_W-1:0] d);
      int ofs;
      int base;
      int n;
      ofs = int'(a) % LINE_BYTES;
      base = int'(a) - ofs;
      n = int'(s);
      if (s == SIZE_FULL) begin
         ofs = 0;
         n = LINE_BYTES;
      end
      for (int i = 0; i < n; i++) begin
         if (ofs + i < LINE_BYTES) begin
            model_mem[base + ofs + i] = d[i*8 +: 8];
         end
      end
   endfunction

   task automatic drive_bus(input src_t s, input logic active, input logic w,
                            input logic [ADR_W-1:0] a, input size_t sz,
                            input logic [LINE_W-1:0] d);
      cyc[s] = active;
      stb[s] = active;
      we[s] = w;
      adr[s] = a;
      req_size[s] = sz;
      dat_w[s] = d;
   endtask

   // One Wishbone classic transfer, latency counted in cycles from stb to ack
   task automatic transfer(input src_t s, input logic w, input logic [ADR_W-1:0] a,
                           input size_t sz, input logic [LINE_W-1:0] d,
                           input string name, output int latency);
      int cycles;
      @(negedge clk);
      drive_bus(s, 1'b1, w, a, sz, d);
      cycles = 1;
      @(negedge clk);
      while (!ack[s] && cycles < ACK_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      latency = cycles;
      if (!ack[s]) begin
         timeouts++;
         $display("Timeout: %s on source %0d got no ack within %0d cycles",
                  name, int'(s), ACK_TIMEOUT);
      end else begin
         order_q.push_back(s);
         if (w) begin
            model_write(a, sz, d);
         end else begin
            exp_q.push_back(expected_read(a, sz));
            act_q.push_back(dat_r[s]);
            name_q.push_back(name);
         end
      end
      drive_bus(s, 1'b0, 1'b0, '0, SIZE_FULL, '0);
   endtask

   // Each master keeps to its own lines, so the model order is per master
   task automatic contend(input src_t s);
      int line_no;
      int ofs;
      int lat;
      size_t sz;
      logic [LINE_W-1:0] d;
      for (int k = 0; k < 2; k++) begin
         line_no = 3 * int'(next_random() % (N_LINES / 3)) + int'(s);
         ofs = int'(next_random() % LINE_BYTES);
         sz = size_t'(next_random() % 5);
         d = random_line();
         transfer(s, 1'b1, make_adr(line_no, ofs), sz, d, "contention", lat);
         transfer(s, 1'b0, make_adr(line_no, ofs), sz, '0, "contention", lat);
      end
   endtask

   always @(posedge clk) begin : compare_reads
      logic [LINE_W-1:0] e;
      logic [LINE_W-1:0] a;
      string n;
      while (exp_q.size() > 0) begin
         e = exp_q.pop_front();
         a = act_q.pop_front();
         n = name_q.pop_front();
         assert (a === e) else begin
            data_errors++;
            $display("ERR %s: expected %h actual %h", n, e, a);
         end
      end
   end

   initial begin
      int lat;
      int line_no;
      int ofs;
      src_t prev;
      rng_state = 32'h8df75f94;
      data_errors = 0;
      check_errors = 0;
      timeouts = 0;
      arst_n = 1'b0;
      for (int s = 0; s < N_SRC; s++) begin
         drive_bus(src_t'(s), 1'b0, 1'b0, '0, SIZE_FULL, '0);
      end
      // ack outputs take their reset value while reset is held
      repeat (4) begin
         @(negedge clk);
         assert (ack == '0) else begin
            check_errors++;
            $display("ERR reset_ack: expected 000 actual %b", ack);
         end
      end
      arst_n = 1'b1;

      repeat (3) begin
         @(negedge clk);
         assert (ack == '0) else begin
            check_errors++;
            $display("ERR reset_ack: expected 000 actual %b", ack);
         end
      end

      // Full line in every bank through the DMA port
      for (int b = 0; b < N_BANKS; b++) begin
         line_no = b * BANK_LINES + int'(next_random() % BANK_LINES);
         transfer(SRC_DMA, 1'b1, make_adr(line_no, 0), SIZE_FULL, fill_line(line_no),
                  "full_line", lat);
         transfer(SRC_DMA, 1'b0, make_adr(line_no, 0), SIZE_FULL, '0, "full_line", lat);
      end

      // First round sits at the line end to force clipping
      for (int k = 0; k < 8; k++) begin
         line_no = int'(next_random() % N_LINES);
         transfer(SRC_DC, 1'b1, make_adr(line_no, 0), SIZE_FULL, random_line(),
                  "partial_base", lat);
         for (int sz = 1; sz <= 4; sz++) begin
            ofs = (k == 0) ? 30 : int'(next_random() % LINE_BYTES);
            transfer(SRC_DC, 1'b1, make_adr(line_no, ofs), size_t'(sz), random_line(),
                     "partial_write", lat);
         end
         ofs = int'(next_random() % LINE_BYTES);
         transfer(SRC_IC, 1'b0, make_adr(line_no, ofs), SIZE_FULL, '0, "partial_write", lat);
         for (int sz = 1; sz <= 4; sz++) begin
            ofs = (k == 0) ? 31 : int'(next_random() % LINE_BYTES);
            transfer(SRC_DC, 1'b0, make_adr(line_no, ofs), size_t'(sz), '0,
                     "partial_read", lat);
         end
      end

      // Idle arbiter: one cycle to grant, one to access
      transfer(SRC_IC, 1'b0, make_adr(line_no, 0), SIZE_FULL, '0, "latency", lat);
      assert (lat == 2) else begin
         check_errors++;
         $display("ERR latency: expected 2 actual %0d", lat);
      end
      @(negedge clk);
      assert (ack == '0) else begin
         check_errors++;
         $display("ERR ack_width: expected 000 actual %b", ack);
      end

      order_q.delete();
      fork
         contend(SRC_IC);
         contend(SRC_DC);
         contend(SRC_DMA);
      join
      assert (order_q.size() == 4 * N_SRC) else begin
         check_errors++;
         $display("ERR round_robin_count: expected %0d actual %0d", 4 * N_SRC, order_q.size());
      end
      // Last owner before the contention was the instruction cache
      prev = SRC_IC;
      for (int i = 0; i < order_q.size(); i++) begin
         assert (order_q[i] == src_t'((int'(prev) + 1) % N_SRC)) else begin
            check_errors++;
            $display("ERR round_robin slot %0d: expected %0d actual %0d", i,
                     (int'(prev) + 1) % N_SRC, int'(order_q[i]));
         end
         prev = order_q[i];
      end

      @(posedge clk);
      @(negedge clk);
      $display("Errors: data %0d, check %0d, timeout %0d", data_errors, check_errors, timeouts);
      if (data_errors + check_errors + timeouts == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* mem_subsystem.f */
mem_pkg.sv
mem_bank.sv
byte_lane_unit.sv
main_memory.sv
mem_arbiter.sv
mem_subsystem.sv
tb_clock_gen.sv
mem_subsystem_assertions.sv
mem_subsystem_tb.sv

/* Makefile */
# Verilator build and run of the memory subsystem testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module mem_subsystem_tb -f mem_subsystem.f
	./obj_dir/Vmem_subsystem_tb | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
